// File: rtl/cpuSettings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction memory size in 32-bit words.
`define IMEM_DEPTH 64

// data memory size in 32-bit words.
`define DMEM_DEPTH 32

// byte address of the first instruction fetched after run goes high.
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/cpuPkg.sv
`include "cpuSettings.svh"

package cpuPkg;

  typedef logic [31:0] word_t;

  typedef logic [4:0] regIdx_t;

  // word address into instruction memory, as used by the load port.
  typedef logic [$clog2(`IMEM_DEPTH)-1:0] imemAddr_t;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt
  } aluOp_t;

  // major opcodes of the supported RV32I subset.
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

endpackage

// File: rtl/FetchUnit.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module FetchUnit import cpuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      run,
  input  logic      stall,
  input  logic      loadValid,
  input  imemAddr_t loadAddr,
  input  word_t     loadData,
  output logic      loadReady,
  output word_t     idInstruction
);

  localparam int IMEM_ADDR_BITS = $bits(imemAddr_t);

  // ADDI x0, x0, 0.
  localparam word_t NOP = 32'h0000_0013;

  word_t     imem [`IMEM_DEPTH];
  word_t     pc;
  word_t     ifInstruction;
  logic      pcInRange;
  imemAddr_t fetchIndex;

  // the program can only be changed while the core is idle.
  assign loadReady = !run;

  always_ff @(posedge clk) begin
    if (loadValid && loadReady) begin
      imem[loadAddr] <= loadData;
    end
  end

  assign fetchIndex = pc[IMEM_ADDR_BITS+1:2];
  assign pcInRange  = pc[31:2] < `IMEM_DEPTH;

  // running past the end of the program fetches no-ops instead of wrapping.
  assign ifInstruction = pcInRange ? imem[fetchIndex] : NOP;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `RESET_PC;
    end else if (!run) begin
      pc <= `RESET_PC;
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      idInstruction <= NOP;
    end else if (!run) begin
      idInstruction <= NOP;
    end else if (!stall) begin
      idInstruction <= ifInstruction;
    end
  end

  // a load lands only while the core is idle.
  loadOnlyWhileIdle: assert property (
    @(posedge clk) disable iff (!rstN)
      (loadValid && loadReady) |-> !run
  );

endmodule

// File: rtl/DecodeUnit.sv
`timescale 1ns/10ps

module DecodeUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  word_t   idInstruction,
  input  word_t   idLhsValue,
  input  word_t   idRhsValue,
  output regIdx_t exLhsIndex,
  output regIdx_t exRhsIndex,
  output regIdx_t exWriteRegisterIndex,
  output word_t   exLhsValue,
  output word_t   exRhsValue,
  output word_t   exImmediate,
  output aluOp_t  exAluOp,
  output logic    exAluSrc,
  output logic    exMemRead,
  output logic    exMemWrite,
  output logic    exMemToReg,
  output logic    exRegWrite,
  output logic    stall
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  regIdx_t    rs1;
  regIdx_t    rs2;
  regIdx_t    rd;
  word_t      immediate;
  aluOp_t     aluOp;
  logic       aluSrc;
  logic       memRead;
  logic       memWrite;
  logic       memToReg;
  logic       regWrite;

  assign opcode = idInstruction[6:0];
  assign funct3 = idInstruction[14:12];
  assign funct7 = idInstruction[31:25];
  assign rs1    = idInstruction[19:15];
  assign rs2    = idInstruction[24:20];
  assign rd     = idInstruction[11:7];

  always_comb begin
    aluOp    = aluAdd;
    aluSrc   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    case (opcode)
      OP_REG: begin
        regWrite = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
        case (funct3)
          3'b000: aluOp = funct7[5] ? aluSub : aluAdd;
          3'b010: aluOp = aluSlt;
          3'b100: aluOp = aluXor;
          3'b110: aluOp = aluOr;
          3'b111: aluOp = aluAnd;
          default: regWrite = 1'b0;
        endcase
      end
      OP_IMM: begin
        // only ADDI is supported among the immediate forms.
        aluSrc   = 1'b1;
        regWrite = (funct3 == 3'b000);
      end
      OP_LOAD: begin
        aluSrc   = 1'b1;
        memRead  = (funct3 == 3'b010);
        memToReg = memRead;
        regWrite = memRead;
      end
      OP_STORE: begin
        aluSrc   = 1'b1;
        memWrite = (funct3 == 3'b010);
      end
      default: begin
      end
    endcase
  end

  // stores split their offset around the rd field.
  assign immediate = (opcode == OP_STORE)
    ? {{20{idInstruction[31]}}, idInstruction[31:25], idInstruction[11:7]}
    : {{20{idInstruction[31]}}, idInstruction[31:20]};

  // the loaded word is not ready until writeback, so a dependent use waits a cycle.
  assign stall = exMemRead && (exWriteRegisterIndex != '0)
    && (exWriteRegisterIndex == rs1 || exWriteRegisterIndex == rs2);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exAluSrc   <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exRegWrite <= 1'b0;
    end else if (stall) begin
      exAluSrc   <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exMemToReg <= 1'b0;
      exRegWrite <= 1'b0;
    end else begin
      exAluSrc   <= aluSrc;
      exMemRead  <= memRead;
      exMemWrite <= memWrite;
      exMemToReg <= memToReg;
      exRegWrite <= regWrite;
    end
  end

  always_ff @(posedge clk) begin
    exLhsIndex           <= rs1;
    exRhsIndex           <= rs2;
    exWriteRegisterIndex <= rd;
    exLhsValue           <= idLhsValue;
    exRhsValue           <= idRhsValue;
    exImmediate          <= immediate;
    exAluOp              <= aluOp;
  end

  // the bubble clears exMemRead, so a stall can never repeat.
  singleCycleStall: assert property (
    @(posedge clk) disable iff (!rstN) stall |=> !stall
  );

endmodule

// File: rtl/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regIdx_t readIndexA,
  input  regIdx_t readIndexB,
  input  regIdx_t writeIndex,
  input  logic    writeEnable,
  input  word_t   writeData,
  output word_t   readDataA,
  output word_t   readDataB
);

  word_t regs [1:31];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeIndex != '0) begin
      regs[writeIndex] <= writeData;
    end
  end

  // a write in the same cycle is passed straight to the reader.
  function automatic word_t readPort(regIdx_t index);
    if (index == '0) begin
      return '0;
    end else if (writeEnable && writeIndex == index) begin
      return writeData;
    end
    return regs[index];
  endfunction

  assign readDataA = readPort(readIndexA);
  assign readDataB = readPort(readIndexB);

endmodule

// File: rtl/ExecuteUnit.sv
`timescale 1ns/10ps

module ExecuteUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  regIdx_t exLhsIndex,
  input  regIdx_t exRhsIndex,
  input  regIdx_t exWriteRegisterIndex,
  input  word_t   exLhsValue,
  input  word_t   exRhsValue,
  input  word_t   exImmediate,
  input  aluOp_t  exAluOp,
  input  logic    exAluSrc,
  input  logic    exMemRead,
  input  logic    exMemWrite,
  input  logic    exMemToReg,
  input  logic    exRegWrite,
  input  regIdx_t wbWriteRegisterIndex,
  input  logic    wbRegWrite,
  input  word_t   writeBackData,
  output word_t   memAluResult,
  output word_t   memStoreData,
  output regIdx_t memWriteRegisterIndex,
  output logic    memMemRead,
  output logic    memMemWrite,
  output logic    memMemToReg,
  output logic    memRegWrite
);

  word_t lhsOperand;
  word_t rhsOperand;
  word_t aluInputB;
  word_t aluResult;

  // the younger producer in memory wins over the one in writeback.
  function automatic word_t forward(regIdx_t index, word_t decodedValue);
    if (memRegWrite && memWriteRegisterIndex != '0 && memWriteRegisterIndex == index) begin
      return memAluResult;
    end else if (wbRegWrite && wbWriteRegisterIndex != '0 && wbWriteRegisterIndex == index) begin
      return writeBackData;
    end
    return decodedValue;
  endfunction

  assign lhsOperand = forward(exLhsIndex, exLhsValue);
  assign rhsOperand = forward(exRhsIndex, exRhsValue);
  assign aluInputB  = exAluSrc ? exImmediate : rhsOperand;

  always_comb begin
    case (exAluOp)
      aluAdd:  aluResult = lhsOperand + aluInputB;
      aluSub:  aluResult = lhsOperand - aluInputB;
      aluAnd:  aluResult = lhsOperand & aluInputB;
      aluOr:   aluResult = lhsOperand | aluInputB;
      aluXor:  aluResult = lhsOperand ^ aluInputB;
      aluSlt:  aluResult = {31'b0, $signed(lhsOperand) < $signed(aluInputB)};
      default: aluResult = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memMemRead  <= 1'b0;
      memMemWrite <= 1'b0;
      memMemToReg <= 1'b0;
      memRegWrite <= 1'b0;
    end else begin
      memMemRead  <= exMemRead;
      memMemWrite <= exMemWrite;
      memMemToReg <= exMemToReg;
      memRegWrite <= exRegWrite;
    end
  end

  // store data takes the forwarded rs2, never the immediate.
  always_ff @(posedge clk) begin
    memAluResult          <= aluResult;
    memStoreData          <= rhsOperand;
    memWriteRegisterIndex <= exWriteRegisterIndex;
  end

endmodule

// File: rtl/MemoryUnit.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module MemoryUnit import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  word_t   memAluResult,
  input  word_t   memStoreData,
  input  regIdx_t memWriteRegisterIndex,
  input  logic    memMemRead,
  input  logic    memMemWrite,
  input  logic    memMemToReg,
  input  logic    memRegWrite,
  output regIdx_t wbWriteRegisterIndex,
  output logic    wbRegWrite,
  output word_t   writeBackData
);

  localparam int DMEM_ADDR_BITS = $clog2(`DMEM_DEPTH);

  word_t                     dmem [`DMEM_DEPTH];
  logic [DMEM_ADDR_BITS-1:0] dmemIndex;
  word_t                     memLoadData;
  word_t                     wbMemoryData;
  word_t                     wbAluResult;
  logic                      wbMemToReg;

  // word addressed, the two low address bits are dropped.
  assign dmemIndex   = memAluResult[DMEM_ADDR_BITS+1:2];
  assign memLoadData = memMemRead ? dmem[dmemIndex] : '0;

  always_ff @(posedge clk) begin
    if (memMemWrite) begin
      dmem[dmemIndex] <= memStoreData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
    end else begin
      wbRegWrite <= memRegWrite;
      wbMemToReg <= memMemToReg;
    end
  end

  always_ff @(posedge clk) begin
    wbWriteRegisterIndex <= memWriteRegisterIndex;
    wbMemoryData         <= memLoadData;
    wbAluResult          <= memAluResult;
  end

  assign writeBackData = wbMemToReg ? wbMemoryData : wbAluResult;

  // an access computed in execute must stay aligned and inside the data memory.
  accessInRange: assert property (
    @(posedge clk) disable iff (!rstN)
      (memMemRead || memMemWrite) |->
        (memAluResult[1:0] == 2'b00) && (memAluResult < `DMEM_DEPTH * 4)
  );

endmodule

// File: rtl/Cpu.sv
`timescale 1ns/10ps

module Cpu import cpuPkg::*; (
  input  logic      clk,
  input  logic      rstN,
  input  logic      run,
  input  logic      loadValid,
  input  imemAddr_t loadAddr,
  input  word_t     loadData,
  output logic      loadReady,
  output logic      retireValid,
  output regIdx_t   retireRegIndex,
  output word_t     retireData
);

  logic    stall;
  word_t   idInstruction;
  regIdx_t idLhsIndex;
  regIdx_t idRhsIndex;
  word_t   idLhsValue;
  word_t   idRhsValue;

  regIdx_t exLhsIndex;
  regIdx_t exRhsIndex;
  regIdx_t exWriteRegisterIndex;
  word_t   exLhsValue;
  word_t   exRhsValue;
  word_t   exImmediate;
  aluOp_t  exAluOp;
  logic    exAluSrc;
  logic    exMemRead;
  logic    exMemWrite;
  logic    exMemToReg;
  logic    exRegWrite;

  word_t   memAluResult;
  word_t   memStoreData;
  regIdx_t memWriteRegisterIndex;
  logic    memMemRead;
  logic    memMemWrite;
  logic    memMemToReg;
  logic    memRegWrite;

  regIdx_t wbWriteRegisterIndex;
  logic    wbRegWrite;
  word_t   writeBackData;

  // source fields go straight to the register file read ports.
  assign idLhsIndex = idInstruction[19:15];
  assign idRhsIndex = idInstruction[24:20];

  FetchUnit fetchUnit (
    .clk           (clk),
    .rstN          (rstN),
    .run           (run),
    .stall         (stall),
    .loadValid     (loadValid),
    .loadAddr      (loadAddr),
    .loadData      (loadData),
    .loadReady     (loadReady),
    .idInstruction (idInstruction)
  );

  RegisterFile registerFile (
    .clk         (clk),
    .rstN        (rstN),
    .readIndexA  (idLhsIndex),
    .readIndexB  (idRhsIndex),
    .writeIndex  (wbWriteRegisterIndex),
    .writeEnable (wbRegWrite),
    .writeData   (writeBackData),
    .readDataA   (idLhsValue),
    .readDataB   (idRhsValue)
  );

  DecodeUnit decodeUnit (
    .clk                  (clk),
    .rstN                 (rstN),
    .idInstruction        (idInstruction),
    .idLhsValue           (idLhsValue),
    .idRhsValue           (idRhsValue),
    .exLhsIndex           (exLhsIndex),
    .exRhsIndex           (exRhsIndex),
    .exWriteRegisterIndex (exWriteRegisterIndex),
    .exLhsValue           (exLhsValue),
    .exRhsValue           (exRhsValue),
    .exImmediate          (exImmediate),
    .exAluOp              (exAluOp),
    .exAluSrc             (exAluSrc),
    .exMemRead            (exMemRead),
    .exMemWrite           (exMemWrite),
    .exMemToReg           (exMemToReg),
    .exRegWrite           (exRegWrite),
    .stall                (stall)
  );

  ExecuteUnit executeUnit (
    .clk                   (clk),
    .rstN                  (rstN),
    .exLhsIndex            (exLhsIndex),
    .exRhsIndex            (exRhsIndex),
    .exWriteRegisterIndex  (exWriteRegisterIndex),
    .exLhsValue            (exLhsValue),
    .exRhsValue            (exRhsValue),
    .exImmediate           (exImmediate),
    .exAluOp               (exAluOp),
    .exAluSrc              (exAluSrc),
    .exMemRead             (exMemRead),
    .exMemWrite            (exMemWrite),
    .exMemToReg            (exMemToReg),
    .exRegWrite            (exRegWrite),
    .wbWriteRegisterIndex  (wbWriteRegisterIndex),
    .wbRegWrite            (wbRegWrite),
    .writeBackData         (writeBackData),
    .memAluResult          (memAluResult),
    .memStoreData          (memStoreData),
    .memWriteRegisterIndex (memWriteRegisterIndex),
    .memMemRead            (memMemRead),
    .memMemWrite           (memMemWrite),
    .memMemToReg           (memMemToReg),
    .memRegWrite           (memRegWrite)
  );

  MemoryUnit memoryUnit (
    .clk                   (clk),
    .rstN                  (rstN),
    .memAluResult          (memAluResult),
    .memStoreData          (memStoreData),
    .memWriteRegisterIndex (memWriteRegisterIndex),
    .memMemRead            (memMemRead),
    .memMemWrite           (memMemWrite),
    .memMemToReg           (memMemToReg),
    .memRegWrite           (memRegWrite),
    .wbWriteRegisterIndex  (wbWriteRegisterIndex),
    .wbRegWrite            (wbRegWrite),
    .writeBackData         (writeBackData)
  );

  // writes to x0 are architecturally invisible and never retire.
  assign retireValid    = wbRegWrite && (wbWriteRegisterIndex != '0);
  assign retireRegIndex = wbWriteRegisterIndex;
  assign retireData     = writeBackData;

endmodule

// File: tests/CpuTb.sv
`timescale 1ns/10ps
`include "cpuSettings.svh"

module CpuTb import cpuPkg::*; ();

  localparam int NUM_PROGRAMS   = 3;
  localparam int PROGRAM_LENGTH = 48;
  localparam int QUIET_CYCLES   = 20;
  // two cycles per instruction slot, plus loading, reset and the quiet tail.
  localparam int CYCLE_LIMIT = NUM_PROGRAMS * `IMEM_DEPTH * 2
    + NUM_PROGRAMS * (`IMEM_DEPTH + 60);

  logic      clk;
  logic      rstN;
  logic      run;
  logic      loadValid;
  imemAddr_t loadAddr;
  word_t     loadData;
  logic      loadReady;
  logic      retireValid;
  regIdx_t   retireRegIndex;
  word_t     retireData;

  word_t   programWords [`IMEM_DEPTH];
  word_t   modelRegs [32];
  word_t   modelMem [`DMEM_DEPTH];
  regIdx_t expIndex [$];
  word_t   expData [$];
  string   testName;
  int      errorCount;
  int      checkCount;
  int      cycleCount;

  Cpu dut_i (
    .clk            (clk),
    .rstN           (rstN),
    .run            (run),
    .loadValid      (loadValid),
    .loadAddr       (loadAddr),
    .loadData       (loadData),
    .loadReady      (loadReady),
    .retireValid    (retireValid),
    .retireRegIndex (retireRegIndex),
    .retireData     (retireData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic word_t encodeReg(logic [6:0] funct7, regIdx_t rs2, regIdx_t rs1,
                                      logic [2:0] funct3, regIdx_t rd);
    return {funct7, rs2, rs1, funct3, rd, OP_REG};
  endfunction

  function automatic word_t encodeImm(logic [6:0] opcode, logic [11:0] imm, regIdx_t rs1,
                                      logic [2:0] funct3, regIdx_t rd);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t encodeStore(logic [11:0] imm, regIdx_t rs2, regIdx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  // builds one random program and runs it on the ISA model at the same time.
  task automatic buildProgram();
    int          kind;
    int          slot;
    int          storedSlots [$];
    regIdx_t     rd;
    regIdx_t     rs1;
    regIdx_t     rs2;
    logic [11:0] imm;
    word_t       a;
    word_t       b;
    word_t       result;
    storedSlots.delete();
    expIndex.delete();
    expData.delete();
    for (int r = 0; r < 32; r++) begin
      modelRegs[r] = '0;
    end
    for (int n = 0; n < `IMEM_DEPTH; n++) begin
      programWords[n] = encodeImm(OP_IMM, 12'h000, 5'd0, 3'b000, 5'd0);
    end
    for (int n = 0; n < PROGRAM_LENGTH; n++) begin
      kind   = int'($urandom_range(8, 0));
      rd     = regIdx_t'($urandom_range(7, 0));
      rs1    = regIdx_t'($urandom_range(7, 0));
      rs2    = regIdx_t'($urandom_range(7, 0));
      imm    = 12'($urandom);
      a      = modelRegs[rs1];
      b      = modelRegs[rs2];
      result = '0;
      // a load needs an address that this program has already written.
      if (kind == 7 && storedSlots.size() == 0) begin
        kind = 6;
      end
      case (kind)
        0: begin
          programWords[n] = encodeReg(7'h00, rs2, rs1, 3'b000, rd);
          result = a + b;
        end
        1: begin
          programWords[n] = encodeReg(7'h20, rs2, rs1, 3'b000, rd);
          result = a - b;
        end
        2: begin
          programWords[n] = encodeReg(7'h00, rs2, rs1, 3'b111, rd);
          result = a & b;
        end
        3: begin
          programWords[n] = encodeReg(7'h00, rs2, rs1, 3'b110, rd);
          result = a | b;
        end
        4: begin
          programWords[n] = encodeReg(7'h00, rs2, rs1, 3'b100, rd);
          result = a ^ b;
        end
        5: begin
          programWords[n] = encodeReg(7'h00, rs2, rs1, 3'b010, rd);
          result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        end
        6: begin
          programWords[n] = encodeImm(OP_IMM, imm, rs1, 3'b000, rd);
          result = a + {{20{imm[11]}}, imm};
        end
        7: begin
          slot = storedSlots[$urandom_range(storedSlots.size() - 1, 0)];
          programWords[n] = encodeImm(OP_LOAD, 12'(slot * 4), 5'd0, 3'b010, rd);
          result = modelMem[slot];
        end
        default: begin
          slot = int'($urandom_range(`DMEM_DEPTH - 1, 0));
          programWords[n] = encodeStore(12'(slot * 4), rs2, 5'd0);
          modelMem[slot] = b;
          storedSlots.push_back(slot);
        end
      endcase
      if (kind != 8 && rd != '0) begin
        modelRegs[rd] = result;
        expIndex.push_back(rd);
        expData.push_back(result);
      end
    end
  endtask

  task automatic applyReset();
    rstN      = 1'b0;
    run       = 1'b0;
    loadValid = 1'b0;
    repeat (4) @(negedge clk);
    rstN = 1'b1;
  endtask

  task automatic loadProgram();
    for (int n = 0; n < `IMEM_DEPTH; n++) begin
      loadValid = 1'b1;
      loadAddr  = imemAddr_t'(n);
      loadData  = programWords[n];
      @(posedge clk);
      checkCount++;
      assert (loadReady) else begin
        errorCount++;
        $display("ERR %s loadReady at word %0d: expected 1, got %0b", testName, n, loadReady);
      end
      @(negedge clk);
    end
    loadValid = 1'b0;
  endtask

  task automatic runProgram(int index);
    testName = $sformatf("randomProgram%0d", index);
    buildProgram();
    applyReset();
    loadProgram();
    run = 1'b1;
    while (expIndex.size() != 0) begin
      @(negedge clk);
    end
    // no-ops keep flowing here and must not retire.
    repeat (QUIET_CYCLES) @(negedge clk);
    run = 1'b0;
    @(negedge clk);
  endtask

  task automatic checkRetire(regIdx_t wantIndex, word_t wantData);
    checkCount++;
    assert (retireRegIndex == wantIndex) else begin
      errorCount++;
      $display("ERR %s retire index: expected x%0d, got x%0d",
               testName, wantIndex, retireRegIndex);
    end
    assert (retireData == wantData) else begin
      errorCount++;
      $display("ERR %s retire data x%0d: expected %h, got %h",
               testName, wantIndex, wantData, retireData);
    end
  endtask

  // outputs are sampled on the rising edge, half a cycle after inputs settle.
  always @(posedge clk) begin
    if (rstN && run) begin
      checkCount++;
      assert (!loadReady) else begin
        errorCount++;
        $display("ERR %s loadReady while running: expected 0, got %0b", testName, loadReady);
      end
    end
    if (rstN && retireValid) begin
      assert (expIndex.size() != 0) else begin
        errorCount++;
        $display("%s: unexpected retire of x%0d when no register write was pending",
                 testName, retireRegIndex);
      end
      if (expIndex.size() != 0) begin
        checkRetire(expIndex.pop_front(), expData.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    rstN       = 1'b0;
    run        = 1'b0;
    loadValid  = 1'b0;
    loadAddr   = '0;
    loadData   = '0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    testName   = "reset";
    void'($urandom(32'h18e1));
    for (int p = 0; p < NUM_PROGRAMS; p++) begin
      runProgram(p);
    end
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: Cpu.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/FetchUnit.sv
rtl/DecodeUnit.sv
rtl/RegisterFile.sv
rtl/ExecuteUnit.sv
rtl/MemoryUnit.sv
rtl/Cpu.sv
tests/CpuTb.sv

// File: Makefile
TOP = CpuTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f Cpu.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
